/* sdram_mcb_defines.svh */
// memory controller widths
`ifndef SDRAM_MCB_DEFINES_SVH
`define SDRAM_MCB_DEFINES_SVH

// user side
`define MCB_ADDR_W      24      // {bank[1:0], row[12:0], col[8:0]}
`define MCB_WORD_W      16      // sdram data word

// page geometry
`define MCB_COL_W       9       // column bits, low end of the address
`define MCB_PAGE_WORDS  512     // one open row

// fifo sizing
`define MCB_FIFO_DEPTH  1024    // entries, both directions
`define MCB_FIFO_CNT_W  11      // fits 0..1024

`endif

/* mcb_user_pkg.sv */
// user side data types
`include "sdram_mcb_defines.svh"

package mcb_user_pkg;

    typedef logic [`MCB_WORD_W-1:0]     word_t;     // one data word
    typedef logic [`MCB_ADDR_W-1:0]     addr_t;     // word address, bank/row/col

    // length is counted in words and spans the whole address range
    typedef logic [`MCB_ADDR_W-1:0]     length_t;   // never zero on load

    typedef logic [`MCB_FIFO_CNT_W-1:0] fifo_cnt_t; // fill level incl. full

endpackage

/* mcb_sched_pkg.sv */
// transfer scheduling types
`include "sdram_mcb_defines.svh"

package mcb_sched_pkg;

    typedef logic [`MCB_COL_W:0] stage_cnt_t;   // 1..512 words per stage

    typedef enum logic [3:0] {
        SCH_IDLE          = 4'd0,   // pick next direction
        SCH_PRE_WR        = 4'd1,   // latch write stage
        SCH_WRITING       = 4'd2,   // wait for write acks
        SCH_WR_STAGE_CPLT = 4'd3,   // write stage closed
        SCH_WR_DONE       = 4'd4,   // write transfer finished
        SCH_PRE_RD        = 4'd5,   // latch read stage
        SCH_READING       = 4'd6,   // wait for read acks
        SCH_RD_STAGE_CPLT = 4'd7,   // read stage closed
        SCH_RD_DONE       = 4'd8    // read transfer finished
    } sched_state_t;

endpackage

/* mcb_fifo.sv */
// show-ahead fifo
`timescale 1ns/100ps
`include "sdram_mcb_defines.svh"

module mcb_fifo #(
    parameter type payload_t = mcb_user_pkg::word_t,   // entry type
    parameter int  DEPTH     = `MCB_FIFO_DEPTH         // number of entries
) (
    input  logic                    clk_sdram,
    input  logic                    rst_n,
    input  logic                    push,       // write one entry
    input  payload_t                push_data,
    input  logic                    pop,        // drop the head entry
    output payload_t                head,       // current head, no latency
    output logic                    full,
    output logic                    empty,
    output mcb_user_pkg::fifo_cnt_t count,      // entries held
    output logic                    overflow,   // push seen while full
    output logic                    underflow   // pop seen while empty
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];  // circular storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push_ok;
    logic             pop_ok;

    assign full    = (count == mcb_user_pkg::fifo_cnt_t'(DEPTH));
    assign empty   = (count == '0);
    assign push_ok = push & ~full;      // illegal push is ignored
    assign pop_ok  = pop & ~empty;      // illegal pop is ignored
    assign head    = mem[rd_ptr];       // show-ahead read

    always_ff @(posedge clk_sdram) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;   // wrap
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none or both
            endcase
            overflow  <= push & full;   // one cycle per dropped word
            underflow <= pop & empty;
        end
    end

endmodule

/* mcb_xfer_channel.sv */
// transfer tracker for one direction
`timescale 1ns/100ps
`include "sdram_mcb_defines.svh"

module mcb_xfer_channel (
    input  logic                      clk_sdram,
    input  logic                      rst_n,
    input  logic                      load,         // level, rising edge loads
    input  mcb_user_pkg::addr_t       load_addr,
    input  mcb_user_pkg::length_t     load_length,
    input  logic                      stage_start,  // from scheduler in PRE state
    input  logic                      word_ack,     // one per burst word
    input  logic                      stage_close,  // last ack of the stage
    output logic                      pending,      // transfer not yet finished
    output mcb_sched_pkg::stage_cnt_t stage_words,  // size of the next stage
    output logic                      burst_req,
    output mcb_user_pkg::addr_t       burst_addr,
    output mcb_sched_pkg::stage_cnt_t burst_len,
    output logic                      stage_end,    // last ack seen now
    output logic                      xfer_last     // nothing left after close
);

    logic                      load_d1;
    logic                      load_pulse;
    mcb_user_pkg::addr_t       cur_addr;    // next stage start address
    mcb_user_pkg::length_t     remain;      // words still to move
    mcb_sched_pkg::stage_cnt_t page_left;   // words up to the page end
    mcb_sched_pkg::stage_cnt_t ack_cnt;     // acks in the current stage
    logic                      in_stage;

    assign load_pulse = load & ~load_d1;

    // stage never crosses a column page
    assign page_left = mcb_sched_pkg::stage_cnt_t'(`MCB_PAGE_WORDS)
                     - {1'b0, cur_addr[`MCB_COL_W-1:0]};
    assign stage_words = (mcb_user_pkg::length_t'(page_left) < remain)
                       ? page_left
                       : mcb_sched_pkg::stage_cnt_t'(remain);   // short tail

    assign burst_addr = cur_addr;       // only moves at stage close
    assign stage_end  = in_stage & word_ack & (ack_cnt == burst_len - 1'b1);
    assign xfer_last  = (remain == '0);

    // load capture and per-stage advance
    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            load_d1  <= 1'b0;
            pending  <= 1'b0;
            cur_addr <= '0;
            remain   <= '0;
        end else begin
            load_d1 <= load;
            if (load_pulse && !pending) begin   // load while busy is dropped
                pending  <= 1'b1;
                cur_addr <= load_addr;
                remain   <= load_length;
            end else if (stage_close) begin
                cur_addr <= cur_addr + mcb_user_pkg::addr_t'(burst_len);
                remain   <= remain - mcb_user_pkg::length_t'(burst_len);
                if (remain == mcb_user_pkg::length_t'(burst_len)) begin
                    pending <= 1'b0;            // final stage closed
                end
            end
        end
    end

    // burst request and ack counting
    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            burst_req <= 1'b0;
            burst_len <= '0;
            ack_cnt   <= '0;
            in_stage  <= 1'b0;
        end else begin
            if (stage_start) begin
                burst_len <= stage_words;       // held for the whole stage
                ack_cnt   <= '0;
                in_stage  <= 1'b1;
                burst_req <= 1'b1;
            end else if (in_stage && word_ack) begin
                ack_cnt   <= ack_cnt + 1'b1;
                burst_req <= 1'b0;              // first ack drops request
                if (stage_end) begin
                    in_stage <= 1'b0;
                end
            end
        end
    end

endmodule

/* mcb_scheduler.sv */
// write and read stage scheduler
`timescale 1ns/100ps
`include "sdram_mcb_defines.svh"

module mcb_scheduler (
    input  logic                      clk_sdram,
    input  logic                      rst_n,
    input  logic                      wr_pending,
    input  logic                      rd_pending,
    input  mcb_sched_pkg::stage_cnt_t wr_stage_words,
    input  mcb_sched_pkg::stage_cnt_t rd_stage_words,
    input  mcb_user_pkg::fifo_cnt_t   wr_fifo_count,    // words ready to write
    input  mcb_user_pkg::fifo_cnt_t   rd_fifo_count,    // words awaiting pop
    input  logic                      wr_stage_end,
    input  logic                      rd_stage_end,
    input  logic                      wr_last,
    input  logic                      rd_last,
    output logic                      wr_stage_start,
    output logic                      rd_stage_start,
    output logic                      wr_stage_close,
    output logic                      rd_stage_close,
    output logic                      wr_done,
    output logic                      rd_done
);

    mcb_sched_pkg::sched_state_t state;
    mcb_sched_pkg::sched_state_t state_next;
    logic                        toggle;        // 1 after a write stage, favors read
    logic                        toggle_next;
    logic [`MCB_FIFO_CNT_W:0]    rd_fill;       // read fill after the stage
    logic                        wr_ok;
    logic                        rd_ok;

    // admission
    assign rd_fill = {1'b0, rd_fifo_count} + (`MCB_FIFO_CNT_W + 1)'(rd_stage_words);
    assign wr_ok   = wr_pending
                   && (wr_fifo_count >= mcb_user_pkg::fifo_cnt_t'(wr_stage_words));
    assign rd_ok   = rd_pending
                   && (rd_fill <= (`MCB_FIFO_CNT_W + 1)'(`MCB_FIFO_DEPTH));

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            state  <= mcb_sched_pkg::SCH_IDLE;
            toggle <= 1'b0;                     // write goes first
        end else begin
            state  <= state_next;
            toggle <= toggle_next;
        end
    end

    always_comb begin
        state_next  = state;
        toggle_next = toggle;
        case (state)
            mcb_sched_pkg::SCH_IDLE: begin
                if (wr_ok && rd_ok) begin       // both ready, alternate
                    state_next = toggle ? mcb_sched_pkg::SCH_PRE_RD
                                        : mcb_sched_pkg::SCH_PRE_WR;
                end else if (wr_ok) begin
                    state_next = mcb_sched_pkg::SCH_PRE_WR;
                end else if (rd_ok) begin
                    state_next = mcb_sched_pkg::SCH_PRE_RD;
                end
            end
            mcb_sched_pkg::SCH_PRE_WR: state_next = mcb_sched_pkg::SCH_WRITING;
            mcb_sched_pkg::SCH_WRITING: begin
                if (wr_stage_end) begin
                    state_next = mcb_sched_pkg::SCH_WR_STAGE_CPLT;
                end
            end
            mcb_sched_pkg::SCH_WR_STAGE_CPLT: begin
                toggle_next = 1'b1;             // read next on contention
                state_next  = wr_last ? mcb_sched_pkg::SCH_WR_DONE
                                      : mcb_sched_pkg::SCH_IDLE;
            end
            mcb_sched_pkg::SCH_WR_DONE: state_next = mcb_sched_pkg::SCH_IDLE;
            mcb_sched_pkg::SCH_PRE_RD:  state_next = mcb_sched_pkg::SCH_READING;
            mcb_sched_pkg::SCH_READING: begin
                if (rd_stage_end) begin
                    state_next = mcb_sched_pkg::SCH_RD_STAGE_CPLT;
                end
            end
            mcb_sched_pkg::SCH_RD_STAGE_CPLT: begin
                toggle_next = 1'b0;             // write next on contention
                state_next  = rd_last ? mcb_sched_pkg::SCH_RD_DONE
                                      : mcb_sched_pkg::SCH_IDLE;
            end
            mcb_sched_pkg::SCH_RD_DONE: state_next = mcb_sched_pkg::SCH_IDLE;
            default:                    state_next = mcb_sched_pkg::SCH_IDLE;
        endcase
    end

    // strobes to the channels, request rises the cycle after PRE
    assign wr_stage_start = (state == mcb_sched_pkg::SCH_PRE_WR);
    assign rd_stage_start = (state == mcb_sched_pkg::SCH_PRE_RD);
    assign wr_stage_close = (state == mcb_sched_pkg::SCH_WRITING) && wr_stage_end;
    assign rd_stage_close = (state == mcb_sched_pkg::SCH_READING) && rd_stage_end;
    assign wr_done        = (state == mcb_sched_pkg::SCH_WR_DONE);  // one cycle
    assign rd_done        = (state == mcb_sched_pkg::SCH_RD_DONE);

endmodule

/* sdram_mcb.sv */
// memory controller front end
`timescale 1ns/100ps
`include "sdram_mcb_defines.svh"

module sdram_mcb (
    input  logic                      clk_sdram,
    input  logic                      rst_n,
    input  logic                      init_done,        // memory init finished
    // user write side
    input  logic                      wr_load,
    input  mcb_user_pkg::addr_t       wr_addr,
    input  mcb_user_pkg::length_t     wr_length,
    input  logic                      wr_req,           // push din
    input  mcb_user_pkg::word_t       din,
    output logic                      wr_rdy,
    output logic                      wr_overrun,
    output logic                      wr_done,
    // user read side
    input  logic                      rd_load,
    input  mcb_user_pkg::addr_t       rd_addr,
    input  mcb_user_pkg::length_t     rd_length,
    input  logic                      rd_req,           // pop dout
    output mcb_user_pkg::word_t       dout,
    output logic                      rd_fifo_empty,
    output mcb_user_pkg::fifo_cnt_t   rd_fifo_cnt,
    output logic                      rd_underrun,
    output logic                      rd_done,
    // burst port, write
    output logic                      burst_wr_req,
    output mcb_user_pkg::addr_t       burst_wr_addr,
    output mcb_sched_pkg::stage_cnt_t burst_wr_len,
    input  logic                      burst_wr_ack,     // one per word
    output mcb_user_pkg::word_t       burst_wr_data,
    // burst port, read
    output logic                      burst_rd_req,
    output mcb_user_pkg::addr_t       burst_rd_addr,
    output mcb_sched_pkg::stage_cnt_t burst_rd_len,
    input  logic                      burst_rd_ack,
    input  mcb_user_pkg::word_t       burst_rd_data
);

    logic                      wr_fifo_full;
    mcb_user_pkg::fifo_cnt_t   wr_fifo_count;
    logic                      wr_pending,  rd_pending;
    mcb_sched_pkg::stage_cnt_t wr_stage_words, rd_stage_words;
    logic                      wr_stage_start, rd_stage_start;
    logic                      wr_stage_close, rd_stage_close;
    logic                      wr_stage_end,   rd_stage_end;
    logic                      wr_last,        rd_last;

    assign wr_rdy = init_done & ~wr_fifo_full;

    mcb_fifo #(.payload_t(mcb_user_pkg::word_t), .DEPTH(`MCB_FIFO_DEPTH)) wr_fifo (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .push(wr_req), .push_data(din), .pop(burst_wr_ack),   // ack pops the head
        .head(burst_wr_data), .full(wr_fifo_full), .empty(), .count(wr_fifo_count),
        .overflow(wr_overrun), .underflow()                   // burst never pops empty
    );

    mcb_fifo #(.payload_t(mcb_user_pkg::word_t), .DEPTH(`MCB_FIFO_DEPTH)) rd_fifo (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .push(burst_rd_ack), .push_data(burst_rd_data), .pop(rd_req),
        .head(dout), .full(), .empty(rd_fifo_empty), .count(rd_fifo_cnt),
        .overflow(), .underflow(rd_underrun)                  // room checked at admission
    );

    mcb_xfer_channel wr_chan (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .load(wr_load), .load_addr(wr_addr), .load_length(wr_length),
        .stage_start(wr_stage_start), .word_ack(burst_wr_ack), .stage_close(wr_stage_close),
        .pending(wr_pending), .stage_words(wr_stage_words), .burst_req(burst_wr_req),
        .burst_addr(burst_wr_addr), .burst_len(burst_wr_len),
        .stage_end(wr_stage_end), .xfer_last(wr_last)
    );

    mcb_xfer_channel rd_chan (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .load(rd_load), .load_addr(rd_addr), .load_length(rd_length),
        .stage_start(rd_stage_start), .word_ack(burst_rd_ack), .stage_close(rd_stage_close),
        .pending(rd_pending), .stage_words(rd_stage_words), .burst_req(burst_rd_req),
        .burst_addr(burst_rd_addr), .burst_len(burst_rd_len),
        .stage_end(rd_stage_end), .xfer_last(rd_last)
    );

    mcb_scheduler scheduler (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .wr_pending(wr_pending), .rd_pending(rd_pending),
        .wr_stage_words(wr_stage_words), .rd_stage_words(rd_stage_words),
        .wr_fifo_count(wr_fifo_count), .rd_fifo_count(rd_fifo_cnt),
        .wr_stage_end(wr_stage_end), .rd_stage_end(rd_stage_end),
        .wr_last(wr_last), .rd_last(rd_last),
        .wr_stage_start(wr_stage_start), .rd_stage_start(rd_stage_start),
        .wr_stage_close(wr_stage_close), .rd_stage_close(rd_stage_close),
        .wr_done(wr_done), .rd_done(rd_done)
    );

endmodule

/* tb_sdram_mcb.sv */
// memory controller testbench
`timescale 1ns/100ps
`include "sdram_mcb_defines.svh"

module tb_sdram_mcb;

    logic clk_sdram, rst_n, init_done;
    logic wr_load, wr_req, wr_rdy, wr_overrun, wr_done;
    logic rd_load, rd_req, rd_fifo_empty, rd_underrun, rd_done;
    logic burst_wr_req, burst_wr_ack, burst_rd_req, burst_rd_ack;
    mcb_user_pkg::addr_t       wr_addr, rd_addr, burst_wr_addr, burst_rd_addr;
    mcb_user_pkg::length_t     wr_length, rd_length;
    mcb_user_pkg::word_t       din, dout, burst_wr_data, burst_rd_data;
    mcb_user_pkg::fifo_cnt_t   rd_fifo_cnt;
    mcb_sched_pkg::stage_cnt_t burst_wr_len, burst_rd_len;

    logic [31:0]               lfsr;            // galois lfsr state
    mcb_user_pkg::word_t       mem_m [mcb_user_pkg::addr_t];   // sdram stand-in
    mcb_user_pkg::word_t       exp_wr_q[$], exp_rd_q[$], last_data[$];
    mcb_user_pkg::addr_t       stg_addr_q[2][$];    // expected stages per direction
    mcb_sched_pkg::stage_cnt_t stg_len_q[2][$];
    mcb_user_pkg::addr_t       act_a[2];            // next burst word address
    int                        act_left[2];         // words left in burst
    int                        rd_cnt_m, wr_done_n, rd_done_n;
    logic                      rd_ack_d, pop_d, force_pop, alt_on, last_dir;
    mcb_user_pkg::addr_t       reg_a[3];
    int                        reg_n[3];

    sdram_mcb uut (.*);

    always #5 clk_sdram = ~clk_sdram;

    task automatic die(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input mcb_user_pkg::word_t got, exp, input string what);
        if (got !== exp) die($sformatf("[ERROR] %0t %s got %h exp %h", $time, what, got, exp));
    endtask
    task automatic check_addr(input mcb_user_pkg::addr_t got, exp, input string what);
        if (got !== exp) die($sformatf("[ERROR] %0t %s got %h exp %h", $time, what, got, exp));
    endtask
    task automatic check_len(input mcb_sched_pkg::stage_cnt_t got, exp, input string what);
        if (got !== exp) die($sformatf("[ERROR] %0t %s got %0d exp %0d", $time, what, got, exp));
    endtask
    task automatic check_count(input mcb_user_pkg::fifo_cnt_t got, exp, input string what);
        if (got !== exp) die($sformatf("[ERROR] %0t %s got %0d exp %0d", $time, what, got, exp));
    endtask
    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) die($sformatf("[ERROR] %0t %s got %b exp %b", $time, what, got, exp));
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ ({32{lfsr[0]}} & 32'h8020_0003);   // one step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // unwritten words read back a pattern of the full address
    function automatic mcb_user_pkg::word_t mem_rd(input mcb_user_pkg::addr_t a);
        return mem_m.exists(a) ? mem_m[a] : (a[15:0] ^ {8'h5a, a[23:16]});
    endfunction

    // split a transfer into page-bounded stages
    task automatic add_stages(input mcb_user_pkg::addr_t a, input int n, input int dir);
        int left, s;
        while (n > 0) begin
            left = `MCB_PAGE_WORDS - int'(a[`MCB_COL_W-1:0]);
            s = (n < left) ? n : left;
            stg_addr_q[dir].push_back(a);
            stg_len_q[dir].push_back(mcb_sched_pkg::stage_cnt_t'(s));
            a = a + mcb_user_pkg::addr_t'(s);
            n = n - s;
        end
    endtask

    // burst side of one direction for one cycle
    task automatic serve_burst(input int dir, input logic req, input mcb_user_pkg::addr_t a,
                               input mcb_sched_pkg::stage_cnt_t len, output logic ack);
        ack = 1'b0;
        if (act_left[dir] == 0 && req) begin       // new stage request
            if (stg_addr_q[dir].size() == 0) die("burst request with no stage expected");
            if (alt_on && stg_addr_q[0].size() > 0 && stg_addr_q[1].size() > 0)
                check_flag(dir[0], !last_dir, "stage direction");
            last_dir = dir[0];
            check_addr(a, stg_addr_q[dir].pop_front(), "burst address");
            check_len(len, stg_len_q[dir].pop_front(), "burst length");
            act_a[dir] = a;
            act_left[dir] = int'(len);
        end
        if (act_left[dir] > 0 && rand_bits(1)) begin    // random gaps between acks
            ack = 1'b1;
            act_left[dir]--;
        end
    endtask

    task automatic tick();
        @(posedge clk_sdram);
        #1;
        rd_cnt_m = rd_cnt_m + int'(rd_ack_d) - int'(pop_d);
        check_count(rd_fifo_cnt, mcb_user_pkg::fifo_cnt_t'(rd_cnt_m), "rd_fifo_cnt");
        check_flag(rd_fifo_empty, rd_cnt_m == 0, "rd_fifo_empty");
        wr_done_n += int'(wr_done);
        rd_done_n += int'(rd_done);
        serve_burst(0, burst_wr_req, burst_wr_addr, burst_wr_len, burst_wr_ack);
        if (burst_wr_ack) begin
            if (exp_wr_q.size() == 0) die("write burst took a word that was never pushed");
            check_word(burst_wr_data, exp_wr_q.pop_front(), "burst write data");
            mem_m[act_a[0]] = burst_wr_data;
            act_a[0]++;
        end
        serve_burst(1, burst_rd_req, burst_rd_addr, burst_rd_len, burst_rd_ack);
        burst_rd_data = burst_rd_ack ? mem_rd(act_a[1]) : 'x;
        if (burst_rd_ack) act_a[1]++;
        rd_ack_d = burst_rd_ack;
        rd_req = force_pop | (!rd_fifo_empty & (exp_rd_q.size() > 0));   // user drains dout
        pop_d = rd_req & (rd_cnt_m > 0);
        if (pop_d) check_word(dout, exp_rd_q.pop_front(), "dout");
    endtask

    task automatic push_words(input int n);
        int guard;
        last_data.delete();
        for (int i = 0; i < n; i++) begin
            guard = 0;
            wr_req = 1'b0;                          // no push while stalled
            while (!wr_rdy) begin
                tick();
                guard++;
                if (guard > 5000) die("timeout waiting for wr_rdy");
            end
            din = mcb_user_pkg::word_t'(rand_bits(16));
            wr_req = 1'b1;
            exp_wr_q.push_back(din);
            last_data.push_back(din);
            tick();
        end
        wr_req = 1'b0;
    endtask

    task automatic wait_dones(input int wr_target, input int rd_target);
        int guard;
        guard = 0;
        while (wr_done_n < wr_target || rd_done_n < rd_target) begin
            tick();
            guard++;
            if (guard > 50000) die("timeout waiting for a done pulse");
        end
    endtask

    task automatic check_region(input mcb_user_pkg::addr_t a);
        foreach (last_data[i]) check_word(mem_rd(a + mcb_user_pkg::addr_t'(i)), last_data[i],
                                          "memory after write");
    endtask

    task automatic expect_read(input mcb_user_pkg::addr_t a, input int n);
        for (int i = 0; i < n; i++) begin
            exp_rd_q.push_back(mem_rd(a + mcb_user_pkg::addr_t'(i)));
        end
        add_stages(a, n, 1);
        rd_addr = a;
        rd_length = mcb_user_pkg::length_t'(n);
    endtask

    initial begin
        clk_sdram = 1'b0;
        rst_n = 1'b0;
        init_done = 1'b0;
        lfsr = 32'ha27b_e839;
        wr_load = 1'b0;
        wr_addr = '0;
        wr_length = '0;
        wr_req = 1'b0;
        din = '0;
        rd_load = 1'b0;
        rd_addr = '0;
        rd_length = '0;
        rd_req = 1'b0;
        burst_wr_ack = 1'b0;
        burst_rd_ack = 1'b0;
        burst_rd_data = '0;
        act_left = '{0, 0};
        rd_cnt_m = 0;
        wr_done_n = 0;
        rd_done_n = 0;
        rd_ack_d = 1'b0;
        pop_d = 1'b0;
        force_pop = 1'b0;
        alt_on = 1'b0;
        last_dir = 1'b1;
        repeat (8) @(posedge clk_sdram);
        #1 rst_n = 1'b1;
        init_done = 1'b1;
        tick();
        check_flag(burst_wr_req | burst_rd_req | wr_done | rd_done, 1'b0, "outputs after reset");
        check_flag(wr_overrun | rd_underrun, 1'b0, "misuse pulses after reset");
        check_flag(rd_fifo_empty, 1'b1, "rd_fifo_empty after reset");
        for (int t = 0; t < 3; t++) begin          // random writes across page ends
            reg_a[t] = mcb_user_pkg::addr_t'(rand_bits(20));
            reg_n[t] = 1 + int'(rand_bits(9)) + int'(rand_bits(8));
            push_words(reg_n[t]);
            add_stages(reg_a[t], reg_n[t], 0);
            wr_addr = reg_a[t];
            wr_length = mcb_user_pkg::length_t'(reg_n[t]);
            wr_load = 1'b1;
            tick();
            wr_load = 1'b0;
            wait_dones(t + 1, 0);
            check_region(reg_a[t]);
        end
        for (int t = 0; t < 3; t++) begin          // read each region back
            expect_read(reg_a[t], reg_n[t]);
            rd_load = 1'b1;
            tick();
            rd_load = 1'b0;
            wait_dones(3, t + 1);
        end
        push_words(700);                           // write and read pending together
        add_stages(24'h20_0100, 700, 0);
        wr_addr = 24'h20_0100;
        wr_length = 24'd700;
        expect_read(reg_a[0], reg_n[0]);
        alt_on = 1'b1;
        wr_load = 1'b1;
        rd_load = 1'b1;
        tick();
        wr_load = 1'b0;
        rd_load = 1'b0;
        wait_dones(4, 4);
        alt_on = 1'b0;
        check_region(24'h20_0100);
        push_words(1024);                          // write fifo now full
        check_flag(wr_rdy, 1'b0, "wr_rdy when full");
        wr_req = 1'b1;
        din = 16'hdead;
        tick();
        wr_req = 1'b0;
        check_flag(wr_overrun, 1'b1, "wr_overrun");
        tick();
        check_flag(wr_overrun, 1'b0, "wr_overrun after one cycle");
        wr_addr = 24'h30_0000 | mcb_user_pkg::addr_t'(rand_bits(9));
        wr_length = 24'd1024;
        add_stages(wr_addr, 1024, 0);
        wr_load = 1'b1;
        tick();
        wr_load = 1'b0;
        tick();
        wr_addr = 24'h00_0007;                     // load while busy is dropped
        wr_load = 1'b1;
        tick();
        wr_load = 1'b0;
        wait_dones(5, 4);
        force_pop = 1'b1;                          // read fifo is empty here
        tick();
        force_pop = 1'b0;
        tick();
        check_flag(rd_underrun, 1'b1, "rd_underrun");
        tick();
        check_flag(rd_underrun, 1'b0, "rd_underrun after one cycle");
        repeat (20) tick();
        if (wr_done_n != 5 || rd_done_n != 4) begin
            die("wrong number of done pulses");
        end else if (stg_addr_q[0].size() != 0 || stg_addr_q[1].size() != 0) begin
            die("expected stages missing");
        end else if (exp_wr_q.size() != 0 || exp_rd_q.size() != 0) begin
            die("words left that never reached the other side");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* sdram_mcb.f */
+incdir+.
mcb_user_pkg.sv
mcb_sched_pkg.sv
mcb_fifo.sv
mcb_xfer_channel.sv
mcb_scheduler.sv
sdram_mcb.sv
tb_sdram_mcb.sv

/* Makefile */
# Verilator build and run for sdram_mcb

VERILATOR ?= verilator
TOP       ?= tb_sdram_mcb
FLIST     ?= sdram_mcb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST)) sdram_mcb_defines.svh
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Some tests failed" $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
